// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // cache geometry, one word per line
    localparam int index_w   = 6;
    localparam int num_lines = 1 << index_w;
    localparam int tag_w     = 8;

    // upper half of every uncached device address
    localparam logic [15:0] uncached_seg = 16'h1c09;

    // icache read sequencer states
    localparam logic [1:0] seq_idle    = 2'd0;
    localparam logic [1:0] seq_fill    = 2'd1;
    localparam logic [1:0] seq_deliver = 2'd2;

    // one fetch address seen two ways
    typedef union packed {
        struct packed {
            logic [15:0]        upper;
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [1:0]         offset;
        } cached;
        struct packed {
            logic [15:0] seg;
            logic [15:0] low;
        } region;
    } fetch_addr_t;

endpackage

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                          clk,
    input  logic                          rst,
    input  fetch_pkg::fetch_addr_t        addr,
    input  logic                          predict_fail,
    input  logic                          boot_done,
    input  logic                          boot_wr,
    input  logic [fetch_pkg::index_w-1:0] boot_index,
    input  logic [fetch_pkg::tag_w-1:0]   boot_tag,
    input  logic [31:0]                   boot_data,
    input  logic [31:0]                   mem_inst,
    output logic [31:0]                   inst,
    output logic                          stall,
    output logic                          refill_req,
    output logic [31:0]                   refill_addr
);

    import fetch_pkg::*;

    logic [num_lines-1:0] valid;
    logic [tag_w-1:0]     tag_mem  [num_lines];
    logic [31:0]          data_mem [num_lines];

    logic [1:0]         state;
    logic [31:0]        uc_word;
    logic [index_w-1:0] idx;
    logic               uncached;
    logic               hit;
    logic               fill_wr;

    assign idx      = addr.cached.index;
    assign uncached = (addr.region.seg == uncached_seg);
    assign hit      = !uncached && valid[idx] && (tag_mem[idx] == addr.cached.tag);

    // memory request goes out in the same cycle the miss is seen
    assign refill_req  = boot_done && (state == seq_idle) && !hit && !predict_fail;
    assign refill_addr = addr;

    // a flushed fill must not land in the array
    assign fill_wr = (state == seq_fill) && !uncached && !predict_fail;

    always_comb begin
        case (state)
            seq_fill:    inst = mem_inst;
            seq_deliver: inst = uc_word;
            default:     inst = data_mem[idx];
        endcase
    end

    assign stall = !predict_fail &&
                   (!boot_done || (state == seq_fill) || ((state == seq_idle) && !hit));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle: begin
                    if (refill_req) begin
                        state <= seq_fill;
                    end
                end
                seq_fill: begin
                    if (!predict_fail && uncached) begin
                        state <= seq_deliver;
                    end else begin
                        state <= seq_idle;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // uncached word held for its single delivery cycle
    always_ff @(posedge clk) begin
        if (state == seq_fill) begin
            uc_word <= mem_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (boot_wr) begin
            valid[boot_index] <= 1'b1;
        end else if (fill_wr) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (boot_wr) begin
            tag_mem[boot_index]  <= boot_tag;
            data_mem[boot_index] <= boot_data;
        end else if (fill_wr) begin
            tag_mem[idx]  <= addr.cached.tag;
            data_mem[idx] <= mem_inst;
        end
    end

    // prefetch writes must all land before the cache opens
    no_boot_wr_after_done: assert property (
        @(posedge clk) disable iff (rst) boot_done |-> !boot_wr
    ) else $error("boot write seen after boot_done");

    // a dropped fetch leaves the sequencer idle
    flush_returns_idle: assert property (
        @(posedge clk) disable iff (rst) predict_fail |=> state == seq_idle
    ) else $error("sequencer left idle after predict_fail");

endmodule

// ==== verilog/boot_prefetch.sv ====
`timescale 1ns/1ps

module boot_prefetch (
    input  logic        clk,
    input  logic        rst,
    output logic        pf_req,
    output logic [31:0] pf_addr,
    output logic        boot_done
);

    import fetch_pkg::*;

    // one extra bit so the count can reach num_lines
    logic [index_w:0] line_cnt;
    logic             walking;
    logic             issue_end;

    assign walking = (line_cnt != num_lines);

    always_ff @(posedge clk) begin
        if (rst) begin
            line_cnt <= '0;
            pf_req   <= 1'b0;
            pf_addr  <= '0;
        end else if (walking) begin
            line_cnt <= line_cnt + 1'b1;
            pf_req   <= 1'b1;
            pf_addr  <= {{(30 - index_w){1'b0}}, line_cnt[index_w-1:0], 2'b00};
        end else begin
            pf_req <= 1'b0;
        end
    end

    // two stages past the last issue so the final word is already written
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_end <= 1'b0;
            boot_done <= 1'b0;
        end else begin
            issue_end <= !walking;
            boot_done <= issue_end;
        end
    end

    // walk starts at word 0 and steps one word per read
    pf_addr_walk: assert property (
        @(posedge clk) disable iff (rst)
        pf_req |-> pf_addr == ($past(pf_req) ? $past(pf_addr) + 32'd4 : 32'd0)
    ) else $error("prefetch address out of sequence");

endmodule

// ==== verilog/mem_port_arbiter.sv ====
`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pf_req,
    input  logic [31:0]                   pf_addr,
    input  logic                          refill_req,
    input  logic [31:0]                   refill_addr,
    input  logic [31:0]                   mem_inst,
    output logic [31:0]                   mem_pc,
    output logic                          boot_wr,
    output logic [fetch_pkg::index_w-1:0] boot_index,
    output logic [fetch_pkg::tag_w-1:0]   boot_tag,
    output logic [31:0]                   boot_data
);

    import fetch_pkg::*;

    // owner of last cycle's read, high means prefetch
    logic        pf_owner;
    logic [31:0] pf_addr_d;
    fetch_addr_t pf_view;

    // prefetch wins, refill only runs once boot is over
    assign mem_pc = pf_req ? pf_addr : refill_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pf_owner <= 1'b0;
        end else begin
            pf_owner <= pf_req;
        end
    end

    always_ff @(posedge clk) begin
        pf_addr_d <= pf_addr;
    end

    // returning word belongs to the address from one cycle back
    assign pf_view    = pf_addr_d;
    assign boot_wr    = pf_owner;
    assign boot_index = pf_view.cached.index;
    assign boot_tag   = pf_view.cached.tag;
    assign boot_data  = mem_inst;

    one_owner: assert property (
        @(posedge clk) disable iff (rst) !(pf_req && refill_req)
    ) else $error("prefetch and refill both want the memory port");

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic        predict_fail,
    output logic [31:0] inst,
    output logic        stall,
    input  logic [31:0] mem_inst,
    output logic [31:0] mem_pc
);

    import fetch_pkg::*;

    logic               pf_req;
    logic [31:0]        pf_addr;
    logic               boot_done;
    logic               refill_req;
    logic [31:0]        refill_addr;
    logic               boot_wr;
    logic [index_w-1:0] boot_index;
    logic [tag_w-1:0]   boot_tag;
    logic [31:0]        boot_data;

    icache i_icache (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .predict_fail (predict_fail),
        .boot_done    (boot_done),
        .boot_wr      (boot_wr),
        .boot_index   (boot_index),
        .boot_tag     (boot_tag),
        .boot_data    (boot_data),
        .mem_inst     (mem_inst),
        .inst         (inst),
        .stall        (stall),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr)
    );

    boot_prefetch i_boot (
        .clk       (clk),
        .rst       (rst),
        .pf_req    (pf_req),
        .pf_addr   (pf_addr),
        .boot_done (boot_done)
    );

    mem_port_arbiter i_arb (
        .clk         (clk),
        .rst         (rst),
        .pf_req      (pf_req),
        .pf_addr     (pf_addr),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .mem_inst    (mem_inst),
        .mem_pc      (mem_pc),
        .boot_wr     (boot_wr),
        .boot_index  (boot_index),
        .boot_tag    (boot_tag),
        .boot_data   (boot_data)
    );

endmodule

// ==== sim/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

    import fetch_pkg::*;

    localparam int stall_limit = 20;
    localparam int boot_limit  = 200;
    localparam int boot_cycles = 66;
    localparam int random_runs = 200;

    logic        clk;
    logic        rst;
    logic [31:0] addr;
    logic        predict_fail;
    logic [31:0] inst;
    logic        stall;
    logic [31:0] mem_inst;
    logic [31:0] mem_pc;

    int errors;
    int timeouts;

    // expected tag per line, boot leaves tag 0 everywhere
    logic [7:0] tag_model [64];

    fetch_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .predict_fail (predict_fail),
        .inst         (inst),
        .stall        (stall),
        .mem_inst     (mem_inst),
        .mem_pc       (mem_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous memory, word one cycle after its address
    always @(posedge clk) begin
        mem_inst <= mem_pc ^ 32'h5a5a_0000;
    end

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic int expected_stalls(input logic [31:0] a);
        if (a[31:16] == uncached_seg) begin
            return 2;
        end
        return (tag_model[a[7:2]] == a[15:8]) ? 0 : 2;
    endfunction

    task automatic report_check(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // present one address, wait out the stall, check count and word
    task automatic fetch_check(input logic [31:0] a, input int exp_stalls);
        int stalls;
        @(posedge clk);
        addr         <= a;
        predict_fail <= 1'b0;
        @(negedge clk);
        stalls = 0;
        if (stall) begin
            assert (mem_pc == a)
                else report_check($sformatf("mem_pc %h, expected %h", mem_pc, a));
        end
        while (stall && stalls < stall_limit) begin
            stalls++;
            @(posedge clk);
            @(negedge clk);
        end
        if (stall) begin
            timeouts++;
            $display("stall never dropped for fetch address %h", a);
        end else begin
            assert (stalls == exp_stalls)
                else report_check($sformatf("addr %h stalled %0d cycles, expected %0d",
                                            a, stalls, exp_stalls));
            assert (inst == model_word(a))
                else report_check($sformatf("addr %h inst %h, expected %h",
                                            a, inst, model_word(a)));
        end
        if (a[31:16] != uncached_seg) begin
            tag_model[a[7:2]] = a[15:8];
        end
    endtask

    task automatic boot_test();
        int  cyc;
        bit  done;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < boot_limit) begin
            @(posedge clk);
            @(negedge clk);
            cyc++;
            if (cyc <= num_lines) begin
                assert (mem_pc == 32'(4 * (cyc - 1)))
                    else report_check($sformatf("boot cycle %0d mem_pc %h, expected %h",
                                                cyc, mem_pc, 4 * (cyc - 1)));
            end
            if (!stall) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            timeouts++;
            $display("stall never dropped after reset");
        end else begin
            assert (cyc == boot_cycles)
                else report_check($sformatf("boot took %0d cycles, expected %0d",
                                            cyc, boot_cycles));
        end
    endtask

    task automatic boot_hit_test();
        for (int i = 0; i < num_lines; i++) begin
            fetch_check(32'(i * 4), 0);
        end
    endtask

    // 0x1040 and 0x0040 share line 16
    task automatic conflict_test();
        fetch_check(32'h0000_1040, 2);
        fetch_check(32'h0000_1040, 0);
        fetch_check(32'h0000_0040, 2);
    endtask

    task automatic uncached_test();
        fetch_check(32'h1c09_0010, 2);
        fetch_check(32'h1c09_0010, 2);
    endtask

    task automatic flush_test();
        logic [31:0] a;
        a = 32'h0000_2080;
        @(posedge clk);
        addr         <= a;
        predict_fail <= 1'b1;
        @(negedge clk);
        assert (!stall)
            else report_check("stall high while predict_fail is high");
        // the dropped miss must not have filled the line
        fetch_check(a, 2);
    endtask

    task automatic random_test();
        logic [31:0] r;
        logic [31:0] a;
        for (int n = 0; n < random_runs; n++) begin
            r = $urandom;
            if (r[31:30] == 2'b00) begin
                a = {uncached_seg, 2'b00, r[13:2], 2'b00};
            end else begin
                a = {18'd0, r[13:2], 2'b00};
            end
            fetch_check(a, expected_stalls(a));
        end
    endtask

    initial begin
        int seed_dummy;
        rst          = 1'b1;
        addr         = '0;
        predict_fail = 1'b0;
        mem_inst     = '0;
        errors       = 0;
        timeouts     = 0;
        foreach (tag_model[i]) begin
            tag_model[i] = 8'h00;
        end
        seed_dummy = $urandom(32'h4751);

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        boot_test();
        boot_hit_test();
        conflict_test();
        uncached_test();
        flush_test();
        random_test();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/fetch_pkg.sv
verilog/icache.sv
verilog/boot_prefetch.sv
verilog/mem_port_arbiter.sv
verilog/fetch_top.sv
sim/tb_fetch.sv
